// ==== mrdma_req_testdata.txt ====
# columns in hex: base_addr line_stride surf_stride width height channel in_precision ram_type perf_en
# last column in decimal: number of requests the operation issues
0000100 10 40 7 3 1f 0 0 1 4
0000200 8 20 f 2 3f 0 1 1 6
0001000 4 10 3 1 3f 1 0 1 8
0000000 0 0 0 0 7f 0 1 1 1
0000040 0 0 0 0 7f 1 0 0 1
1234560 20 100 1f 5 5f 0 0 0 18
7fff000 2 8 1 0 1f 1 1 1 2
0000010 3 9 0 3 1f 0 0 1 4
0100000 40 200 a 4 7f 1 1 1 40
0000000 0 0 0 0 0 0 0 1 1
0030000 11 55 2 2 ff 0 0 1 24
0000abc 1 3 1fff 1 1f 0 1 0 2
0002000 40 400 7 7 ff 1 0 1 128
0005555 0 0 0 0 1fff 1 1 1 1
0000400 10 80 3 3 1f 0 0 1 4
0000300 5 30 4 0 3f 1 0 1 4
0000000 0 0 0 0 1fff 0 0 1 1
0004000 100 1000 0 1 1f 1 1 0 4
0000777 7 77 5 6 20 0 1 1 14
0000100 10 40 7 3 1f 0 1 0 4
0000060 1 2 1 1 1 1 0 1 2
0000000 0 0 0 0 3f 1 1 0 1

// ==== mrdma_req.f ====
+incdir+.
mrdma_req_pkg.sv
mrdma_cfg_decode.sv
mrdma_cube_walker.sv
mrdma_req_issue.sv
mrdma_req_top.sv
tb_mrdma_req.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the mrdma_req testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -f mrdma_req.f --top-module tb_mrdma_req -o tb_mrdma_req

./obj_dir/tb_mrdma_req 2>&1 | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== tb_mrdma_req.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrdma_req_params.svh"

module tb_mrdma_req
  import mrdma_req_pkg::*;
();

  // cycles allowed for one operation to drain
  localparam int op_timeout_cycles = 5000;

  logic            nvdla_core_clk = 1'b0;
  logic            nvdla_core_rstn;
  logic            op_load;
  mrdma_reg_cfg_t  reg_cfg;
  mrdma_dma_req_t  dma_rd_req;
  logic            dma_rd_req_ram_type;
  logic            dma_rd_req_vld;
  logic            dma_rd_req_rdy;
  mrdma_cq_entry_t cq_entry;
  logic            cq_vld;
  logic            cq_rdy;
  logic [31:0]     mrdma_stall;

  logic [31:0]     lfsr_state;
  // predicted requests of the running operation
  mrdma_dma_req_t  exp_req_q[$];
  mrdma_cq_entry_t exp_cq_q[$];

  always #5 nvdla_core_clk = ~nvdla_core_clk;

  mrdma_req_top dut (
    .nvdla_core_clk      (nvdla_core_clk),
    .nvdla_core_rstn     (nvdla_core_rstn),
    .op_load             (op_load),
    .reg_cfg             (reg_cfg),
    .dma_rd_req          (dma_rd_req),
    .dma_rd_req_ram_type (dma_rd_req_ram_type),
    .dma_rd_req_vld      (dma_rd_req_vld),
    .dma_rd_req_rdy      (dma_rd_req_rdy),
    .cq_entry            (cq_entry),
    .cq_vld              (cq_vld),
    .cq_rdy              (cq_rdy),
    .mrdma_stall         (mrdma_stall)
  );

  // ==================================================
  // ready patterns
  // ==================================================

  // x^32 + x^22 + x^2 + x + 1 in right shifting form
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  task automatic take_bit(output logic b);
    b = lfsr_state[0];
    lfsr_state = galois_step(lfsr_state);
  endtask

  // each ready is the or of two bits and is high three cycles in four
  task automatic drive_readies();
    logic a;
    logic b;
    take_bit(a);
    take_bit(b);
    dma_rd_req_rdy = a | b;
    take_bit(a);
    take_bit(b);
    cq_rdy = a | b;
  endtask

  // ==================================================
  // checks
  // ==================================================

  task automatic fail_and_stop();
    $display("TB FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_dma_req(input mrdma_dma_req_t got, input mrdma_dma_req_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED dma_rd_req addr %h size %h expected addr %h size %h",
               got.addr, got.size, exp.addr, exp.size);
      fail_and_stop();
    end
  endtask

  task automatic check_cq_entry(input mrdma_cq_entry_t got, input mrdma_cq_entry_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED cq_entry size %h cube_end %h expected size %h cube_end %h",
               got.size, got.cube_end, exp.size, exp.cube_end);
      fail_and_stop();
    end
  endtask

  task automatic check_stall(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED mrdma_stall got %h expected %h", got, exp);
      fail_and_stop();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      fail_and_stop();
    end
  endtask

  // ==================================================
  // reference walk
  // ==================================================

  task automatic build_expected(input mrdma_reg_cfg_t c);
    logic [8:0]      surfs;
    logic [26:0]     atom;
    mrdma_dma_req_t  r;
    mrdma_cq_entry_t e;
    int              s;
    int              h;
    exp_req_q.delete();
    exp_cq_q.delete();
    // surfaces minus one with 32 or 16 channels each
    if (c.in_precision == 2'(`MRDMA_PREC_INT8)) begin
      surfs = 9'(c.channel / 13'd32);
    end else begin
      surfs = 9'(c.channel / 13'd16);
    end
    if (c.width == 13'd0 && c.height == 13'd0) begin
      // 1x1 pack reads every surface in one request
      r.addr = 32'(c.base_addr) * 32'd32;
      r.size = 15'(surfs);
      e.size = 13'(surfs);
      e.cube_end = 1'b1;
      exp_req_q.push_back(r);
      exp_cq_q.push_back(e);
    end else begin
      for (s = 0; s <= int'(surfs); s++) begin
        for (h = 0; h <= int'(c.height); h++) begin
          atom = c.base_addr + 27'(h) * c.line_stride + 27'(s) * c.surf_stride;
          r.addr = 32'(atom) * 32'd32;
          r.size = 15'(c.width);
          e.size = c.width;
          e.cube_end = (s == int'(surfs)) && (h == int'(c.height));
          exp_req_q.push_back(r);
          exp_cq_q.push_back(e);
        end
      end
    end
  endtask

  // ==================================================
  // one operation
  // ==================================================

  task automatic run_operation(input mrdma_reg_cfg_t c, input int exp_count, input int op_num);
    int          idx;
    int          cycles;
    int unsigned stalls;
    build_expected(c);
    if (exp_req_q.size() != exp_count) begin
      $display("operation %0d: test data expects %0d requests but the walk gives %0d",
               op_num, exp_count, exp_req_q.size());
      fail_and_stop();
    end
    reg_cfg = c;
    op_load = 1'b1;
    drive_readies();
    @(negedge nvdla_core_clk);
    op_load = 1'b0;
    // counter cleared by op_load
    check_stall(mrdma_stall, 32'd0);
    idx = 0;
    cycles = 0;
    stalls = 0;
    while (idx < exp_count) begin
      drive_readies();
      #1;
      // valids are cross gated by the other ready
      check_flag("dma_rd_req_vld", dma_rd_req_vld, cq_rdy);
      check_flag("cq_vld", cq_vld, dma_rd_req_rdy);
      if (dma_rd_req_vld) begin
        check_dma_req(dma_rd_req, exp_req_q[idx]);
        check_flag("dma_rd_req_ram_type", dma_rd_req_ram_type, c.ram_type);
      end
      if (cq_vld) begin
        check_cq_entry(cq_entry, exp_cq_q[idx]);
      end
      if (dma_rd_req_vld && !dma_rd_req_rdy) begin
        stalls++;
      end
      if (dma_rd_req_vld && dma_rd_req_rdy) begin
        idx++;
      end
      cycles++;
      if (cycles > op_timeout_cycles) begin
        $display("timeout: operation %0d issued %0d of %0d requests", op_num, idx, exp_count);
        fail_and_stop();
      end
      @(negedge nvdla_core_clk);
    end
    // nothing more may be offered once the cube is done
    dma_rd_req_rdy = 1'b1;
    cq_rdy = 1'b1;
    repeat (3) begin
      #1;
      check_flag("dma_rd_req_vld", dma_rd_req_vld, 1'b0);
      check_flag("cq_vld", cq_vld, 1'b0);
      @(negedge nvdla_core_clk);
    end
    check_stall(mrdma_stall, c.perf_en ? 32'(stalls) : 32'd0);
  endtask

  // ==================================================
  // main sequence
  // ==================================================

  initial begin
    int             fd;
    int             rc;
    int             n_ops;
    string          line;
    logic [31:0]    f_base;
    logic [31:0]    f_lstr;
    logic [31:0]    f_sstr;
    logic [31:0]    f_w;
    logic [31:0]    f_h;
    logic [31:0]    f_c;
    logic [31:0]    f_prec;
    logic [31:0]    f_ram;
    logic [31:0]    f_perf;
    int             f_count;
    mrdma_reg_cfg_t cfg;
    nvdla_core_rstn = 1'b0;
    op_load = 1'b0;
    reg_cfg = '0;
    dma_rd_req_rdy = 1'b0;
    cq_rdy = 1'b0;
    lfsr_state = 32'h367367ad;
    repeat (5) @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
    check_flag("dma_rd_req_vld", dma_rd_req_vld, 1'b0);
    check_flag("cq_vld", cq_vld, 1'b0);
    check_stall(mrdma_stall, 32'd0);
    fd = $fopen("mrdma_req_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open mrdma_req_testdata.txt");
      fail_and_stop();
    end
    n_ops = 0;
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      // skip comments and empty lines
      if (rc > 0 && line.len() > 1 && line[0] != "#") begin
        rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %d", f_base, f_lstr, f_sstr,
                     f_w, f_h, f_c, f_prec, f_ram, f_perf, f_count);
        if (rc != 10) begin
          $display("malformed line in test data: %s", line);
          fail_and_stop();
        end
        cfg.base_addr    = f_base[26:0];
        cfg.line_stride  = f_lstr[26:0];
        cfg.surf_stride  = f_sstr[26:0];
        cfg.width        = f_w[12:0];
        cfg.height       = f_h[12:0];
        cfg.channel      = f_c[12:0];
        cfg.in_precision = f_prec[1:0];
        cfg.ram_type     = f_ram[0];
        cfg.perf_en      = f_perf[0];
        run_operation(cfg, f_count, n_ops);
        n_ops++;
      end
    end
    $fclose(fd);
    if (n_ops == 0) begin
      $display("no operations found in test data");
      fail_and_stop();
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== mrdma_req_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrdma_req_params.svh"

module mrdma_req_top
  import mrdma_req_pkg::*;
(
  input  wire                 nvdla_core_clk,
  input  wire                 nvdla_core_rstn,
  input  wire                 op_load,
  input  wire mrdma_reg_cfg_t reg_cfg,
  output mrdma_dma_req_t      dma_rd_req,
  output logic                dma_rd_req_ram_type,
  output logic                dma_rd_req_vld,
  input  wire                 dma_rd_req_rdy,
  output mrdma_cq_entry_t     cq_entry,
  output logic                cq_vld,
  input  wire                 cq_rdy,
  output logic [31:0]         mrdma_stall
);

  mrdma_op_cfg_t                     op_cfg;
  logic                              active;
  logic                              accept;
  logic [`MRDMA_ATOM_ADDR_WIDTH-1:0] req_atom_addr;
  logic [`MRDMA_SIZE_WIDTH-1:0]      req_size;
  logic                              cube_end;

  // ==================================================
  // decode then walk then issue
  // ==================================================

  mrdma_cfg_decode u_cfg_decode (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .reg_cfg         (reg_cfg),
    .accept          (accept),
    .cube_end        (cube_end),
    .op_cfg          (op_cfg),
    .active          (active)
  );

  // address and size of the request on offer
  mrdma_cube_walker u_cube_walker (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .reg_cfg         (reg_cfg),
    .op_cfg          (op_cfg),
    .accept          (accept),
    .req_atom_addr   (req_atom_addr),
    .req_size        (req_size),
    .cube_end        (cube_end)
  );

  mrdma_req_issue u_req_issue (
    .nvdla_core_clk      (nvdla_core_clk),
    .nvdla_core_rstn     (nvdla_core_rstn),
    .op_load             (op_load),
    .reg_cfg             (reg_cfg),
    .active              (active),
    .req_atom_addr       (req_atom_addr),
    .req_size            (req_size),
    .cube_end            (cube_end),
    .dma_rd_req_rdy      (dma_rd_req_rdy),
    .cq_rdy              (cq_rdy),
    .accept              (accept),
    .dma_rd_req          (dma_rd_req),
    .dma_rd_req_ram_type (dma_rd_req_ram_type),
    .dma_rd_req_vld      (dma_rd_req_vld),
    .cq_entry            (cq_entry),
    .cq_vld              (cq_vld),
    .mrdma_stall         (mrdma_stall)
  );

endmodule

`default_nettype wire

// ==== mrdma_req_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrdma_req_params.svh"

module mrdma_req_issue
  import mrdma_req_pkg::*;
(
  input  wire                                nvdla_core_clk,
  input  wire                                nvdla_core_rstn,
  input  wire                                op_load,
  input  wire mrdma_reg_cfg_t                reg_cfg,
  input  wire                                active,
  input  wire [`MRDMA_ATOM_ADDR_WIDTH-1:0]   req_atom_addr,
  input  wire [`MRDMA_SIZE_WIDTH-1:0]        req_size,
  input  wire                                cube_end,
  input  wire                                dma_rd_req_rdy,
  input  wire                                cq_rdy,
  output logic                               accept,
  output mrdma_dma_req_t                     dma_rd_req,
  output logic                               dma_rd_req_ram_type,
  output logic                               dma_rd_req_vld,
  output mrdma_cq_entry_t                    cq_entry,
  output logic                               cq_vld,
  output logic [31:0]                        mrdma_stall
);

  logic stall_cen;
  logic stall_inc;

  // ==================================================
  // joint handshake
  // ==================================================

  // each valid waits for the other side's ready
  // so dma and cq take the request in the same cycle
  assign dma_rd_req_vld = active && cq_rdy;
  assign cq_vld         = active && dma_rd_req_rdy;
  assign accept         = dma_rd_req_vld && dma_rd_req_rdy;

  // atom address back to bytes
  assign dma_rd_req.addr      = {req_atom_addr, {`MRDMA_ATOM_SHIFT{1'b0}}};
  assign dma_rd_req.size      = req_size;
  assign dma_rd_req_ram_type  = reg_cfg.ram_type;

  // context queue keeps the size for the return path
  assign cq_entry.size     = req_size[`MRDMA_DIM_WIDTH-1:0];
  assign cq_entry.cube_end = cube_end;

  // ==================================================
  // stall counter
  // ==================================================

  // request offered but memory side not ready
  assign stall_inc = dma_rd_req_vld && !dma_rd_req_rdy;

  // enable sampled per operation
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_cen <= 1'b0;
    end else if (op_load) begin
      stall_cen <= reg_cfg.perf_en;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      mrdma_stall <= '0;
    end else if (op_load) begin
      mrdma_stall <= '0;
    end else if (stall_cen && stall_inc) begin
      mrdma_stall <= mrdma_stall + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== mrdma_cube_walker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrdma_req_params.svh"

module mrdma_cube_walker
  import mrdma_req_pkg::*;
(
  input  wire                                nvdla_core_clk,
  input  wire                                nvdla_core_rstn,
  input  wire                                op_load,
  input  wire mrdma_reg_cfg_t                reg_cfg,
  input  wire mrdma_op_cfg_t                 op_cfg,
  input  wire                                accept,
  output logic [`MRDMA_ATOM_ADDR_WIDTH-1:0]  req_atom_addr,
  output logic [`MRDMA_SIZE_WIDTH-1:0]       req_size,
  output logic                               cube_end
);

  // line index inside the current surface
  logic [`MRDMA_DIM_WIDTH-1:0]       count_h;
  // surface index inside the cube
  logic [`MRDMA_SURF_WIDTH-1:0]      count_c;
  logic [`MRDMA_ATOM_ADDR_WIDTH-1:0] base_addr_line;
  logic [`MRDMA_ATOM_ADDR_WIDTH-1:0] base_addr_surf;
  logic [`MRDMA_ATOM_ADDR_WIDTH-1:0] next_surf_addr;
  logic                              is_last_h;
  logic                              is_last_c;
  logic                              is_surf_end;

  // ==================================================
  // cube shape
  // ==================================================

  assign is_last_h = (count_h == reg_cfg.height);
  assign is_last_c = (count_c == op_cfg.surf_count);

  // every request covers a full line
  // so each accept is a line end
  assign is_surf_end = op_cfg.mode_1x1_pack || is_last_h;
  assign cube_end    = is_surf_end && (op_cfg.mode_1x1_pack || is_last_c);

  // line counter
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_h <= '0;
    end else if (op_load) begin
      count_h <= '0;
    end else if (accept) begin
      if (is_surf_end) begin
        count_h <= '0;
      end else begin
        count_h <= count_h + 1'b1;
      end
    end
  end

  // surface counter
  // wraps to zero at the cube end
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_c <= '0;
    end else if (op_load) begin
      count_c <= '0;
    end else if (accept) begin
      if (cube_end) begin
        count_c <= '0;
      end else if (is_surf_end) begin
        count_c <= count_c + 1'b1;
      end
    end
  end

  // ==================================================
  // address walk
  // ==================================================

  // start of the following surface
  assign next_surf_addr = base_addr_surf + reg_cfg.surf_stride;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_addr_line <= '0;
      base_addr_surf <= '0;
    end else if (op_load) begin
      base_addr_line <= reg_cfg.base_addr;
      base_addr_surf <= reg_cfg.base_addr;
    end else if (accept) begin
      if (is_surf_end) begin
        // first line of the new surface
        base_addr_line <= next_surf_addr;
        base_addr_surf <= next_surf_addr;
      end else begin
        base_addr_line <= base_addr_line + reg_cfg.line_stride;
      end
    end
  end

  assign req_atom_addr = base_addr_line;

  // ==================================================
  // request size
  // ==================================================

  // 1x1 pack reads all surfaces in one go
  always_comb begin
    if (op_cfg.mode_1x1_pack) begin
      req_size = {{(`MRDMA_SIZE_WIDTH-`MRDMA_SURF_WIDTH){1'b0}}, op_cfg.surf_count};
    end else begin
      req_size = {{(`MRDMA_SIZE_WIDTH-`MRDMA_DIM_WIDTH){1'b0}}, reg_cfg.width};
    end
  end

endmodule

`default_nettype wire

// ==== mrdma_cfg_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mrdma_req_params.svh"

module mrdma_cfg_decode
  import mrdma_req_pkg::*;
(
  input  wire                 nvdla_core_clk,
  input  wire                 nvdla_core_rstn,
  input  wire                 op_load,
  input  wire mrdma_reg_cfg_t reg_cfg,
  input  wire                 accept,
  input  wire                 cube_end,
  output mrdma_op_cfg_t       op_cfg,
  output logic                active
);

  // ==================================================
  // mode decode
  // ==================================================

  always_comb begin
    // whole cube is one line of one pixel
    op_cfg.mode_1x1_pack = (reg_cfg.width == '0) && (reg_cfg.height == '0);
    // surfaces in channel direction
    case (reg_cfg.in_precision)
      `MRDMA_PREC_INT8: begin
        // 32 channels per surface
        op_cfg.surf_count = {1'b0, reg_cfg.channel[`MRDMA_DIM_WIDTH-1:`MRDMA_ATOM_SHIFT]};
      end
      `MRDMA_PREC_INT16: begin
        // 16 channels per surface
        op_cfg.surf_count = reg_cfg.channel[`MRDMA_DIM_WIDTH-1:`MRDMA_ATOM_SHIFT-1];
      end
      default: begin
        // unknown codes walk like int16
        op_cfg.surf_count = reg_cfg.channel[`MRDMA_DIM_WIDTH-1:`MRDMA_ATOM_SHIFT-1];
      end
    endcase
  end

  // ==================================================
  // operation active
  // ==================================================

  // set at op_load and dropped after the last request goes out
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      active <= 1'b0;
    end else if (op_load) begin
      active <= 1'b1;
    end else if (accept && cube_end) begin
      active <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== mrdma_req_pkg.sv ====
`default_nettype none

`include "mrdma_req_params.svh"

package mrdma_req_pkg;

  // ==================================================
  // register side
  // ==================================================

  // all dimensions hold value minus one
  typedef struct packed {
    logic [`MRDMA_ATOM_ADDR_WIDTH-1:0] base_addr;
    // strides count atoms
    logic [`MRDMA_ATOM_ADDR_WIDTH-1:0] line_stride;
    logic [`MRDMA_ATOM_ADDR_WIDTH-1:0] surf_stride;
    logic [`MRDMA_DIM_WIDTH-1:0]       width;
    logic [`MRDMA_DIM_WIDTH-1:0]       height;
    logic [`MRDMA_DIM_WIDTH-1:0]       channel;
    logic [1:0]                        in_precision;
    logic                              ram_type;
    logic                              perf_en;
  } mrdma_reg_cfg_t;

  // decoded operation mode
  typedef struct packed {
    logic                         mode_1x1_pack;
    // number of surfaces minus one
    logic [`MRDMA_SURF_WIDTH-1:0] surf_count;
  } mrdma_op_cfg_t;

  // ==================================================
  // request side
  // ==================================================

  // low atom bits of addr are always zero
  typedef struct packed {
    logic [`MRDMA_ADDR_WIDTH-1:0] addr;
    logic [`MRDMA_SIZE_WIDTH-1:0] size;
  } mrdma_dma_req_t;

  // one entry per request for the return path
  typedef struct packed {
    logic [`MRDMA_DIM_WIDTH-1:0] size;
    logic                        cube_end;
  } mrdma_cq_entry_t;

endpackage

`default_nettype wire

// ==== mrdma_req_params.svh ====
`ifndef MRDMA_REQ_PARAMS_SVH
`define MRDMA_REQ_PARAMS_SVH

// ==================================================
// address widths
// ==================================================

// byte address on the memory request
`define MRDMA_ADDR_WIDTH 32
// one atom is 32 bytes
`define MRDMA_ATOM_SHIFT 5
// address in atom units
`define MRDMA_ATOM_ADDR_WIDTH 27

// ==================================================
// cube and request fields
// ==================================================

// width height and channel registers
`define MRDMA_DIM_WIDTH 13
`define MRDMA_SURF_WIDTH 9
`define MRDMA_SIZE_WIDTH 15

// in_precision codes
`define MRDMA_PREC_INT8 0
`define MRDMA_PREC_INT16 1

`endif
